//--- design/simple_processor_params.svh
////////////////////////////////////////
// simple processor widths
////////////////////////////////////////

`ifndef SIMPLE_PROCESSOR_PARAMS_SVH
`define SIMPLE_PROCESSOR_PARAMS_SVH

// memory address bus width
`define SP_ADDR_W 16

// data word, also the instruction word
`define SP_DATA_W 16

// register index, eight registers
`define SP_REG_AW 3

// raw immediate field
`define SP_IMM_W 6

`endif

//--- design/simple_processor_pkg.sv
////////////////////////////////////////
// simple processor types
////////////////////////////////////////

`include "simple_processor_params.svh"

package simple_processor_pkg;

  typedef logic [`SP_ADDR_W-1:0] addr_t;      // byte address
  typedef logic [`SP_DATA_W-1:0] data_t;      // data / instruction word
  typedef logic [`SP_REG_AW-1:0] reg_addr_t;  // register index
  typedef logic [`SP_IMM_W-1:0]  imm_t;       // raw imm field, zero extended later

  // instruction opcodes, bits [15:12] of the word
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_ADD   = 4'h1,
    OP_SUB   = 4'h2,
    OP_AND   = 4'h3,
    OP_OR    = 4'h4,
    OP_XOR   = 4'h5,
    OP_ADDI  = 4'h6,
    OP_LUI6  = 4'h7,  // rd = zext(imm)
    OP_LOAD  = 4'h8,  // rd = mem[rs1 + imm]
    OP_STORE = 4'h9   // mem[rs1 + imm] = reg in rd field
  } opcode_e;

  // execution functions
  typedef enum logic [2:0] {
    F_ADD,
    F_SUB,
    F_AND,
    F_OR,
    F_XOR,
    F_PASS_IMM,
    F_MEM       // address add, direction from is_load / is_store
  } func_t;

endpackage

//--- design/dec_if.sv
////////////////////////////////////////
// decoder to datapath bundle
////////////////////////////////////////

interface dec_if
  import simple_processor_pkg::*;
();

  logic      inst_valid;  // fetched word present
  func_t     func;        // execution function
  logic      use_imm;     // operand b from imm
  logic      is_load;
  logic      is_store;
  logic      we;          // instruction writes rd
  reg_addr_t rd_addr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  imm_t      imm;

  modport dec (output inst_valid, func, use_imm, is_load, is_store, we,
               output rd_addr, rs1_addr, rs2_addr, imm);
  modport rf  (input rd_addr, rs1_addr, rs2_addr);
  modport ex  (input inst_valid, func, use_imm, imm, is_load, is_store, we);

endinterface

//--- design/ins_dec.sv
////////////////////////////////////////
// instruction decoder
////////////////////////////////////////

module ins_dec
  import simple_processor_pkg::*;
(
  input  data_t imem_rdata_i,  // fetched word
  input  logic  imem_ack_i,    // word is valid this cycle
  dec_if.dec    dec
);

  opcode_e opcode;

  assign opcode = opcode_e'(imem_rdata_i[15:12]);

  always_comb begin
    // defaults decode as nop
    dec.inst_valid = imem_ack_i;
    dec.func       = F_ADD;
    dec.use_imm    = 1'b0;
    dec.is_load    = 1'b0;
    dec.is_store   = 1'b0;
    dec.we         = 1'b0;
    dec.rd_addr    = imem_rdata_i[11:9];
    dec.rs1_addr   = imem_rdata_i[8:6];
    dec.rs2_addr   = imem_rdata_i[5:3];  // overlaps imm, only reg ops use it
    dec.imm        = imem_rdata_i[5:0];

    if (imem_ack_i) begin
      case (opcode)
        OP_ADD:  begin dec.func = F_ADD;  dec.we = 1'b1; end
        OP_SUB:  begin dec.func = F_SUB;  dec.we = 1'b1; end
        OP_AND:  begin dec.func = F_AND;  dec.we = 1'b1; end
        OP_OR:   begin dec.func = F_OR;   dec.we = 1'b1; end
        OP_XOR:  begin dec.func = F_XOR;  dec.we = 1'b1; end
        OP_ADDI: begin
          dec.func    = F_ADD;
          dec.use_imm = 1'b1;
          dec.we      = 1'b1;
        end
        OP_LUI6: begin
          dec.func = F_PASS_IMM;
          dec.we   = 1'b1;
        end
        OP_LOAD: begin
          dec.func    = F_MEM;
          dec.use_imm = 1'b1;
          dec.is_load = 1'b1;
          dec.we      = 1'b1;  // gated by dmem ack downstream
        end
        OP_STORE: begin
          dec.func     = F_MEM;
          dec.use_imm  = 1'b1;
          dec.is_store = 1'b1;
          // store data register sits in the rd field since imm takes [5:0]
          dec.rs2_addr = imem_rdata_i[11:9];
        end
        default: begin
          dec.func = F_ADD;  // nop and unknown opcodes, no write
        end
      endcase
    end
  end

endmodule

//--- design/reg_file.sv
////////////////////////////////////////
// register file, 8 x 16
////////////////////////////////////////

module reg_file
  import simple_processor_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_ni,
  dec_if.rf     rf,          // register addresses
  input  logic  rf_we_i,     // write rd this edge
  input  data_t rd_data_i,
  output data_t rs1_data_o,
  output data_t rs2_data_o
);

  localparam int NumRegs = 1 << $bits(reg_addr_t);

  data_t regs_q [NumRegs];  // x0 is a normal register

  // single write port
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rf_we_i) begin
      regs_q[rf.rd_addr] <= rd_data_i;
    end
  end

  // async reads, no bypass
  assign rs1_data_o = regs_q[rf.rs1_addr];
  assign rs2_data_o = regs_q[rf.rs2_addr];

endmodule

//--- design/merge_execution.sv
////////////////////////////////////////
// alu and data memory port
////////////////////////////////////////

module merge_execution
  import simple_processor_pkg::*;
(
  dec_if.ex     ex,            // decoded controls

  input  data_t rs1_data_i,
  input  data_t rs2_data_i,    // alu operand or store data

  input  data_t dmem_rdata_i,  // valid with ack
  input  logic  dmem_ack_i,

  output data_t rd_data_o,     // write-back value
  output logic  rf_we_o,
  output logic  stall_o,       // mem op waiting on ack

  output logic  dmem_req_o,
  output logic  dmem_we_o,
  output addr_t dmem_addr_o,
  output data_t dmem_wdata_o
);

  ////////////////////////////////////////
  // operands and alu
  ////////////////////////////////////////

  data_t imm_ext;   // zero extended imm
  data_t op_b;
  data_t alu_res;
  logic  mem_op;    // live load or store

  assign imm_ext = data_t'(ex.imm);
  assign op_b    = ex.use_imm ? imm_ext : rs2_data_i;

  always_comb begin
    case (ex.func)
      F_ADD:      alu_res = rs1_data_i + op_b;
      F_SUB:      alu_res = rs1_data_i - op_b;
      F_AND:      alu_res = rs1_data_i & op_b;
      F_OR:       alu_res = rs1_data_i | op_b;
      F_XOR:      alu_res = rs1_data_i ^ op_b;
      F_PASS_IMM: alu_res = imm_ext;
      F_MEM:      alu_res = rs1_data_i + op_b;  // effective address
      default:    alu_res = '0;
    endcase
  end

  ////////////////////////////////////////
  // data memory request
  ////////////////////////////////////////

  assign mem_op = ex.inst_valid & (ex.is_load | ex.is_store);

  // operands stay put while stalled, so addr and wdata hold with req
  assign dmem_req_o   = mem_op;
  assign dmem_we_o    = mem_op & ex.is_store;
  assign dmem_addr_o  = addr_t'(alu_res);
  assign dmem_wdata_o = rs2_data_i;

  assign stall_o = mem_op & ~dmem_ack_i;  // released in the ack cycle

  ////////////////////////////////////////
  // write-back
  ////////////////////////////////////////

  assign rd_data_o = ex.is_load ? dmem_rdata_i : alu_res;

  // loads write only once read data arrives
  assign rf_we_o = ex.inst_valid & ex.we & (~ex.is_load | dmem_ack_i);

endmodule

//--- design/simple_processor.sv
////////////////////////////////////////
// simple processor top
////////////////////////////////////////

`include "simple_processor_params.svh"

module simple_processor
  import simple_processor_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = `SP_ADDR_W,  // memory address bus
  parameter int MEM_DATA_WIDTH = `SP_DATA_W   // memory data bus
) (
  input  logic                      clk_i,
  input  logic                      arst_ni,
  input  addr_t                     boot_addr_i,   // first fetch address

  output logic                      imem_req_o,
  output logic [MEM_ADDR_WIDTH-1:0] imem_addr_o,
  input  logic [MEM_DATA_WIDTH-1:0] imem_rdata_i,
  input  logic                      imem_ack_i,

  output logic                      dmem_req_o,
  output logic                      dmem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0] dmem_addr_o,
  output logic [MEM_DATA_WIDTH-1:0] dmem_wdata_o,
  input  logic [MEM_DATA_WIDTH-1:0] dmem_rdata_i,
  input  logic                      dmem_ack_i
);

  ////////////////////////////////////////
  // fetch and pc
  ////////////////////////////////////////

  addr_t pc_q;
  logic  booted_q;    // boot address loaded
  logic  held_q;      // mem op in flight, word parked in ir_q
  data_t ir_q;        // parked instruction
  data_t fetch_word;  // word seen by decoder
  logic  fetch_ack;   // decoder has a word
  logic  stall;
  logic  consumed;    // instruction retires this edge
  data_t rd_data;
  data_t rs1_data;
  data_t rs2_data;
  logic  rf_we;

  assign imem_req_o  = booted_q;  // high for good after boot
  assign imem_addr_o = pc_q;

  assign fetch_word = held_q ? ir_q : imem_rdata_i;
  assign fetch_ack  = held_q | (booted_q & imem_ack_i);
  assign consumed   = fetch_ack & ~stall;

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      pc_q     <= '0;
      booted_q <= 1'b0;
      held_q   <= 1'b0;
    end else begin
      held_q <= stall;  // drops at the edge after dmem ack
      if (!booted_q) begin
        pc_q     <= boot_addr_i;
        booted_q <= 1'b1;
      end else if (consumed) begin
        pc_q <= pc_q + addr_t'(2);
      end
    end
  end

  // park the word on the first stall cycle, imem ack may vanish after
  always_ff @(posedge clk_i) begin
    if (stall && !held_q) begin
      ir_q <= imem_rdata_i;
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  dec_if u_dec_if ();

  ins_dec u_ins_dec (
    .imem_rdata_i (fetch_word),
    .imem_ack_i   (fetch_ack),
    .dec          (u_dec_if.dec)
  );

  reg_file u_reg_file (
    .clk_i,
    .arst_ni,
    .rf         (u_dec_if.rf),
    .rf_we_i    (rf_we),     // from ex, load waits for ack
    .rd_data_i  (rd_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  merge_execution u_merge_execution (
    .ex           (u_dec_if.ex),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .dmem_rdata_i,
    .dmem_ack_i,
    .rd_data_o    (rd_data),
    .rf_we_o      (rf_we),
    .stall_o      (stall),
    .dmem_req_o,
    .dmem_we_o,
    .dmem_addr_o,
    .dmem_wdata_o
  );

endmodule

//--- tb/simple_processor_tb.sv
////////////////////////////////////////
// simple processor testbench
////////////////////////////////////////

module simple_processor_tb
  import simple_processor_pkg::*;
();

  localparam addr_t BootAddr  = 16'h0040;
  localparam int    ProgBase  = 16;    // golden word offsets
  localparam int    DataBase  = 64;
  localparam int    StoreBase = 80;
  localparam int    MaxCycles = 2000;

  logic   clk_i = 1'b0;
  logic   arst_ni, imem_req, imem_ack, dmem_req, dmem_we, dmem_ack;
  addr_t  boot_addr, imem_addr, dmem_addr;
  data_t  imem_rdata, dmem_wdata, dmem_rdata;
  data_t  golden [128];
  data_t  imem [128];                // word index addr[7:1]
  data_t  dmem [32];                 // word index addr[5:1]
  integer seed = 65;
  int     rnd, wait_cnt, cycles, store_idx, n_stores;
  logic   pending, req_we;           // open data request and its direction
  addr_t  req_addr, exp_pc;
  data_t  req_wdata;

  always #5 clk_i = ~clk_i;

  simple_processor u_dut (
    .clk_i        (clk_i),
    .arst_ni      (arst_ni),
    .boot_addr_i  (boot_addr),
    .imem_req_o   (imem_req),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .imem_ack_i   (imem_ack),
    .dmem_req_o   (dmem_req),
    .dmem_we_o    (dmem_we),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_rdata_i (dmem_rdata),
    .dmem_ack_i   (dmem_ack)
  );

  ////////////////////////////////////////
  // compare helpers
  ////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_on_error($sformatf("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
                            $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_we(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  ////////////////////////////////////////
  // memory models
  ////////////////////////////////////////

  // runs 1 unit after the rising edge
  task automatic drive_memories();
    dmem_ack = 1'b0;
    if (pending) begin
      if (wait_cnt == 0) begin
        dmem_ack = 1'b1;              // one cycle ack
        if (req_we) begin
          dmem[req_addr[5:1]] = req_wdata;
        end else begin
          dmem_rdata = dmem[req_addr[5:1]];
        end
      end else begin
        wait_cnt--;
      end
    end
    rnd        = $random(seed);
    imem_ack   = imem_req & (rnd[1:0] != 2'b00);  // withheld about 1 in 4
    imem_rdata = imem[imem_addr[7:1]];
  endtask

  // runs at the falling edge once everything has settled
  task automatic watch_outputs();
    check_we("imem_req_o", imem_req, 1'b1);
    check_addr("imem_addr_o", imem_addr, exp_pc);
    // plain op retires on imem ack and mem op on dmem ack
    if (dmem_req ? dmem_ack : imem_ack) exp_pc = exp_pc + 16'd2;
    if (pending) begin
      // request must hold through the ack cycle
      check_we("dmem_req_o", dmem_req, 1'b1);
      check_we("dmem_we_o", dmem_we, req_we);
      check_addr("dmem_addr_o", dmem_addr, req_addr);
      if (req_we) check_data("dmem_wdata_o", dmem_wdata, req_wdata);
      if (dmem_ack) pending = 1'b0;
    end else if (dmem_req) begin
      pending   = 1'b1;
      rnd       = $random(seed);
      wait_cnt  = rnd & 3;            // 0..3 idle cycles before ack
      req_addr  = dmem_addr;
      req_we    = dmem_we;
      req_wdata = dmem_wdata;
      if (dmem_we) begin
        if (store_idx >= n_stores) stop_on_error("a store came after the last expected one");
        check_addr("dmem_addr_o", dmem_addr, golden[7'(StoreBase + 2 * store_idx)]);
        check_data("dmem_wdata_o", dmem_wdata, golden[7'(StoreBase + 2 * store_idx + 1)]);
        store_idx++;
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int n_prog;
    int n_data;
    arst_ni    = 1'b0;
    boot_addr  = BootAddr;
    imem_ack   = 1'b0;
    imem_rdata = '0;
    dmem_ack   = 1'b0;
    dmem_rdata = '0;
    store_idx  = 0;
    pending    = 1'b0;
    req_we     = 1'b0;
    wait_cnt   = 0;
    exp_pc     = '0;
    for (int i = 0; i < 128; i++) imem[7'(i)] = {4'h0, 12'(i)};   // nops with fields from address
    for (int i = 0; i < 32; i++) dmem[5'(i)] = {8'hd0, 8'(i)};
    $readmemh("tb/simple_processor_golden.txt", golden);
    n_prog   = int'(golden[0]);
    n_data   = int'(golden[1]);
    n_stores = int'(golden[2]);
    for (int i = 0; i < n_prog; i++) imem[BootAddr[7:1] + 7'(i)] = golden[7'(ProgBase + i)];
    for (int i = 0; i < n_data; i++) dmem[5'(i)] = golden[7'(DataBase + i)];

    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_we("imem_req_o", imem_req, 1'b0);
    check_we("dmem_req_o", dmem_req, 1'b0);
    check_addr("imem_addr_o", imem_addr, '0);
    @(posedge clk_i);
    #1 arst_ni = 1'b1;

    cycles = 0;
    while (imem_req !== 1'b1) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20) stop_on_error("imem_req_o did not rise after reset");
    end
    check_addr("imem_addr_o", imem_addr, BootAddr);
    exp_pc = BootAddr;

    cycles = 0;
    while (store_idx < n_stores || pending) begin
      @(posedge clk_i);
      #1;
      drive_memories();
      @(negedge clk_i);
      watch_outputs();
      cycles++;
      if (cycles > MaxCycles) stop_on_error("timed out before all expected stores completed");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- all.f
+incdir+design
design/simple_processor_pkg.sv
design/dec_if.sv
design/ins_dec.sv
design/reg_file.sv
design/merge_execution.sv
design/simple_processor.sv
tb/simple_processor_tb.sv

//--- Makefile
# Verilator build and run for the simple processor

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= simple_processor_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails if $(LOG) reports a failure"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/simple_processor_golden.txt
// hex words: counts at 000 (program words, data words, store pairs), program at 010,
// initial data memory at 040 (from address 0), expected stores at 050 as address then data
0013 0004 0008
@010
7215 // lui6 x1, 0x15          -> 0015
742A // lui6 x2, 0x2a          -> 002a
1650 // add  x3, x1, x2        -> 003f
2850 // sub  x4, x1, x2        -> ffeb
3AE0 // and  x5, x3, x4        -> 002b
4C60 // or   x6, x1, x4        -> ffff
5EA0 // xor  x7, x2, x4        -> ffc1
627F // addi x1, x1, 0x3f      -> 0054
0FFF // nop with stray fields
FE3F // unknown opcode f
8404 // load  x2, [x0 + 0x04]  -> beef
9010 // store x0, [x0 + 0x10]
9212 // store x1, [x0 + 0x12]
9414 // store x2, [x0 + 0x14]
9616 // store x3, [x0 + 0x16]
9818 // store x4, [x0 + 0x18]
9A1A // store x5, [x0 + 0x1a]
9C1C // store x6, [x0 + 0x1c]
9E1E // store x7, [x0 + 0x1e]
@040
1111 2222 BEEF 4444
@050
0010 0000  0012 0054
0014 BEEF  0016 003F
0018 FFEB  001A 002B
001C FFFF  001E FFC1
